//--- common/ing_defines.svh
// Sizing macros for the ingress stage of the packet router
// Include wherever a bus, buffer or counter width is needed
`ifndef ING_DEFINES_SVH
`define ING_DEFINES_SVH

// Converged bus and port count
`define ING_BUS_BYTES     8
`define ING_NUM_PORTS     4
`define ING_PORT_IDX_W    2

// Per-port buffer sizes, in wide beats and in whole packets
`define ING_BEAT_DEPTH    16
`define ING_DESC_DEPTH    4

// Largest packet in wide beats, and the width of a beat count (1 to 8)
`define ING_MAX_PKT_BEATS 8
`define ING_BEATS_W       4

// Packet and drop counters
`define ING_CNT_W         16

`endif

//--- common/ing_pkg.sv
// Types shared by the ingress adapters, port buffers and scheduler
`default_nettype none
`include "ing_defines.svh"

package ing_pkg;

    // One converged-bus beat
    // Byte 0 of data sits in the low bits, one keep bit per byte
    typedef struct packed {
        logic [`ING_BUS_BYTES*8-1:0] data;
        logic [`ING_BUS_BYTES-1:0]   keep;
    } wide_beat_t;

    // Descriptor of one fully buffered packet
    typedef struct packed {
        logic [`ING_BEATS_W-1:0] beats;
    } pkt_desc_t;

endpackage

`default_nettype wire

//--- ing_port_buf/ing_pkt_fifo.sv
// Show-ahead synchronous FIFO with a free-entry count
// Holds either wide beats or packet descriptors, chosen by payload_t
`timescale 1ns/1ps
`default_nettype none

module ing_pkt_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 16
) (
    input  logic                   ing_bus,
    input  logic                   arst_n,
    input  logic                   push,
    input  payload_t               push_data,
    input  logic                   pop,
    output payload_t               head,
    output logic                   not_empty,
    output logic [$clog2(DEPTH):0] free
);

    // DEPTH is a power of two, so pointers wrap by themselves
    localparam int             AW       = $clog2(DEPTH);
    localparam logic [AW:0]    FULL_CNT = DEPTH[AW:0];

    payload_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_push;
    logic          do_pop;

    assign do_push   = push & (count != FULL_CNT);
    assign do_pop    = pop & not_empty;
    assign not_empty = (count != '0);
    assign free      = FULL_CNT - count;

    // Head is visible before the pop
    assign head = mem[rd_ptr];

    always_ff @(posedge ing_bus) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge ing_bus or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + {{AW{1'b0}}, do_push} - {{AW{1'b0}}, do_pop};
        end
    end

endmodule

`default_nettype wire

//--- ing_port_buf/ing_port_buf.sv
// Per-port packet buffer with whole-packet drop and packet counters
// Feeds complete packets to the scheduler through a descriptor queue
`timescale 1ns/1ps
`default_nettype none
`include "ing_defines.svh"

module ing_port_buf
    import ing_pkg::*;
(
    input  logic                  ing_bus,
    input  logic                  arst_n,
    input  logic                  enable,
    input  logic                  cnt_clear,
    input  logic                  adapt_valid,
    input  wide_beat_t            adapt_beat,
    input  logic                  adapt_last,
    input  logic                  desc_pop,
    input  logic                  beat_pop,
    output logic                  adapt_ready,
    output logic                  desc_avail,
    output pkt_desc_t             desc_head,
    output wide_beat_t            beat_head,
    output logic [`ING_CNT_W-1:0] pkt_cnt,
    output logic [`ING_CNT_W-1:0] drop_cnt
);

    localparam int BEAT_FREE_W = $clog2(`ING_BEAT_DEPTH) + 1;
    localparam int DESC_FREE_W = $clog2(`ING_DESC_DEPTH) + 1;

    logic                    in_pkt;
    logic                    storing;
    logic                    first_beat;
    logic                    room;
    logic                    store_beat;
    logic                    store_last;
    logic                    drop_pkt;
    logic [`ING_BEATS_W-1:0] beat_cnt;
    logic [BEAT_FREE_W-1:0]  beat_free;
    logic [DESC_FREE_W-1:0]  desc_free;
    pkt_desc_t               desc_new;

    // Full buffers drop whole packets instead of stalling the port
    assign adapt_ready = 1'b1;

    ////////////////////////////////////////////////////////////////////////////
    // Packet admission

    // Fate of the packet is fixed at its first beat
    assign first_beat = adapt_valid & ~in_pkt;
    assign room       = (beat_free >= BEAT_FREE_W'(`ING_MAX_PKT_BEATS)) &
                        (desc_free != '0);
    assign store_beat = adapt_valid & (first_beat ? (enable & room) : storing);
    assign store_last = store_beat & adapt_last;
    assign drop_pkt   = first_beat & enable & ~room;

    assign desc_new.beats = beat_cnt + 1'b1;

    always_ff @(posedge ing_bus or negedge arst_n) begin
        if (!arst_n) begin
            in_pkt   <= 1'b0;
            storing  <= 1'b0;
            beat_cnt <= '0;
        end else begin
            if (adapt_valid) begin
                in_pkt <= ~adapt_last;
            end
            if (first_beat) begin
                storing <= enable & room;
            end
            if (store_last) begin
                beat_cnt <= '0;
            end else if (store_beat) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // Clear wins over a same-cycle increment
    always_ff @(posedge ing_bus or negedge arst_n) begin
        if (!arst_n) begin
            pkt_cnt  <= '0;
            drop_cnt <= '0;
        end else if (cnt_clear) begin
            pkt_cnt  <= '0;
            drop_cnt <= '0;
        end else begin
            if (store_last) begin
                pkt_cnt <= pkt_cnt + 1'b1;
            end
            if (drop_pkt) begin
                drop_cnt <= drop_cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Beat and descriptor queues

    ing_pkt_fifo #(
        .payload_t ( wide_beat_t     ),
        .DEPTH     ( `ING_BEAT_DEPTH )
    ) u_beat_fifo (
        .ing_bus   ( ing_bus    ),
        .arst_n    ( arst_n     ),
        .push      ( store_beat ),
        .push_data ( adapt_beat ),
        .pop       ( beat_pop   ),
        .head      ( beat_head  ),
        .not_empty (            ),
        .free      ( beat_free  )
    );

    ing_pkt_fifo #(
        .payload_t ( pkt_desc_t      ),
        .DEPTH     ( `ING_DESC_DEPTH )
    ) u_desc_fifo (
        .ing_bus   ( ing_bus    ),
        .arst_n    ( arst_n     ),
        .push      ( store_last ),
        .push_data ( desc_new   ),
        .pop       ( desc_pop   ),
        .head      ( desc_head  ),
        .not_empty ( desc_avail ),
        .free      ( desc_free  )
    );

endmodule

`default_nettype wire

//--- hw/ing_port_adapt.sv
// Packs narrow ingress beats into converged-bus beats with byte keep
// One instance per physical port, IN_BYTES set to that port's width
`timescale 1ns/1ps
`default_nettype none
`include "ing_defines.svh"

module ing_port_adapt
    import ing_pkg::*;
#(
    parameter int IN_BYTES = 2
) (
    input  logic                  ing_bus,
    input  logic                  arst_n,
    input  logic                  in_valid,
    input  logic [IN_BYTES*8-1:0] in_data,
    input  logic                  in_last,
    input  logic                  adapt_ready,
    output logic                  in_ready,
    output logic                  adapt_valid,
    output wide_beat_t            adapt_beat,
    output logic                  adapt_last
);

    localparam int LANES  = `ING_BUS_BYTES / IN_BYTES;
    localparam int LANE_W = (LANES > 1) ? $clog2(LANES) : 1;

    logic [LANE_W-1:0]           lane;
    logic [`ING_BUS_BYTES*8-1:0] acc_data;
    logic [`ING_BUS_BYTES*8-1:0] next_data;
    logic [`ING_BUS_BYTES-1:0]   next_keep;
    logic                        in_fire;
    logic                        complete;

    // Input stalls only while a packed beat waits for the buffer
    assign in_ready = ~adapt_valid | adapt_ready;
    assign in_fire  = in_valid & in_ready;

    // Wide beat done when all lanes are filled or the packet ends
    assign complete = in_fire & (in_last | (lane == LANE_W'(LANES - 1)));

    // Merge the current input beat into its lane
    always_comb begin
        next_data = acc_data;
        next_data[lane*IN_BYTES*8 +: IN_BYTES*8] = in_data;
        for (int b = 0; b < `ING_BUS_BYTES; b++) begin
            next_keep[b] = (b < (int'(lane) + 1) * IN_BYTES);
        end
    end

    always_ff @(posedge ing_bus or negedge arst_n) begin
        if (!arst_n) begin
            lane        <= '0;
            acc_data    <= '0;
            adapt_valid <= 1'b0;
        end else begin
            if (complete) begin
                lane     <= '0;
                acc_data <= '0;
            end else if (in_fire) begin
                lane     <= lane + 1'b1;
                acc_data <= next_data;
            end

            if (complete) begin
                adapt_valid <= 1'b1;
            end else if (adapt_ready) begin
                adapt_valid <= 1'b0;
            end
        end
    end

    // Packed beat, held until the buffer takes it
    always_ff @(posedge ing_bus) begin
        if (complete) begin
            adapt_beat.data <= next_data;
            adapt_beat.keep <= next_keep;
            adapt_last      <= in_last;
        end
    end

endmodule

`default_nettype wire

//--- hw/ing_sched.sv
// Round-robin packet scheduler that merges the port buffers onto the ingress bus
// Each beat carries its source port index on bus_user
`timescale 1ns/1ps
`default_nettype none
`include "ing_defines.svh"

module ing_sched
    import ing_pkg::*;
(
    input  logic                            ing_bus,
    input  logic                            arst_n,
    input  logic [`ING_NUM_PORTS-1:0]       desc_avail,
    input  pkt_desc_t [`ING_NUM_PORTS-1:0]  desc_head,
    input  wide_beat_t [`ING_NUM_PORTS-1:0] beat_head,
    input  logic                            bus_ready,
    output logic [`ING_NUM_PORTS-1:0]       desc_pop,
    output logic [`ING_NUM_PORTS-1:0]       beat_pop,
    output logic                            bus_valid,
    output logic [`ING_BUS_BYTES*8-1:0]     bus_data,
    output logic [`ING_BUS_BYTES-1:0]       bus_keep,
    output logic                            bus_last,
    output logic [`ING_PORT_IDX_W-1:0]      bus_user
);

    logic                       busy;
    logic [`ING_PORT_IDX_W-1:0] cur_port;
    logic [`ING_BEATS_W-1:0]    remain;
    logic                       found;
    logic [`ING_PORT_IDX_W-1:0] pick;
    logic                       bus_fire;

    ////////////////////////////////////////////////////////////////////////////
    // Grant

    // Search upward from the port after the last grant
    always_comb begin
        found = 1'b0;
        pick  = cur_port;
        for (int i = 1; i <= `ING_NUM_PORTS; i++) begin
            if (!found && desc_avail[(int'(cur_port) + i) % `ING_NUM_PORTS]) begin
                found = 1'b1;
                pick  = `ING_PORT_IDX_W'((int'(cur_port) + i) % `ING_NUM_PORTS);
            end
        end
    end

    assign bus_fire = bus_valid & bus_ready;

    always_comb begin
        desc_pop           = '0;
        beat_pop           = '0;
        desc_pop[pick]     = ~busy & found;
        beat_pop[cur_port] = bus_fire;
    end

    // Starts at port 0 after reset
    always_ff @(posedge ing_bus or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            cur_port <= `ING_PORT_IDX_W'(`ING_NUM_PORTS - 1);
            remain   <= '0;
        end else if (!busy) begin
            if (found) begin
                busy     <= 1'b1;
                cur_port <= pick;
                remain   <= desc_head[pick].beats;
            end
        end else if (bus_fire) begin
            remain <= remain - 1'b1;
            if (bus_last) begin
                busy <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Ingress bus

    assign bus_valid = busy;
    assign bus_data  = beat_head[cur_port].data;
    assign bus_keep  = beat_head[cur_port].keep;
    assign bus_user  = cur_port;
    // Countdown is zero when idle
    assign bus_last  = (remain == `ING_BEATS_W'(1));

endmodule

`default_nettype wire

//--- hw/ing_top.sv
// Ingress stage top level: four port adapters and buffers into one scheduler
// Ports 0 and 1 are 2 bytes wide, ports 2 and 3 are 4 bytes wide
`timescale 1ns/1ps
`default_nettype none
`include "ing_defines.svh"

module ing_top
    import ing_pkg::*;
(
    input  logic                        ing_bus,
    input  logic                        arst_n,
    input  logic [`ING_NUM_PORTS-1:0]   in_valid,
    input  logic [15:0]                 in_data_0,
    input  logic [15:0]                 in_data_1,
    input  logic [31:0]                 in_data_2,
    input  logic [31:0]                 in_data_3,
    input  logic [`ING_NUM_PORTS-1:0]   in_last,
    input  logic [`ING_NUM_PORTS-1:0]   port_enable,
    input  logic [`ING_NUM_PORTS-1:0]   cnt_clear,
    input  logic                        bus_ready,
    output logic [`ING_NUM_PORTS-1:0]   in_ready,
    output logic                        bus_valid,
    output logic [`ING_BUS_BYTES*8-1:0] bus_data,
    output logic [`ING_BUS_BYTES-1:0]   bus_keep,
    output logic                        bus_last,
    output logic [`ING_PORT_IDX_W-1:0]  bus_user,
    output logic [`ING_CNT_W-1:0]       pkt_cnt  [`ING_NUM_PORTS-1:0],
    output logic [`ING_CNT_W-1:0]       drop_cnt [`ING_NUM_PORTS-1:0]
);

    localparam int NUM_16B = 2;

    logic [15:0]                     data_16b [NUM_16B];
    logic [31:0]                     data_32b [`ING_NUM_PORTS-NUM_16B];
    logic [`ING_NUM_PORTS-1:0]       adapt_valid;
    logic [`ING_NUM_PORTS-1:0]       adapt_ready;
    logic [`ING_NUM_PORTS-1:0]       adapt_last;
    wide_beat_t [`ING_NUM_PORTS-1:0] adapt_beat;
    logic [`ING_NUM_PORTS-1:0]       desc_avail;
    pkt_desc_t [`ING_NUM_PORTS-1:0]  desc_head;
    wide_beat_t [`ING_NUM_PORTS-1:0] beat_head;
    logic [`ING_NUM_PORTS-1:0]       desc_pop;
    logic [`ING_NUM_PORTS-1:0]       beat_pop;

    assign data_16b[0] = in_data_0;
    assign data_16b[1] = in_data_1;
    assign data_32b[0] = in_data_2;
    assign data_32b[1] = in_data_3;

    ////////////////////////////////////////////////////////////////////////////
    // Per-port width adaptation and buffering

    for (genvar p = 0; p < `ING_NUM_PORTS; p++) begin : g_port
        if (p < NUM_16B) begin : g_16b
            ing_port_adapt #(
                .IN_BYTES ( 2 )
            ) u_adapt (
                .ing_bus     ( ing_bus        ),
                .arst_n      ( arst_n         ),
                .in_valid    ( in_valid[p]    ),
                .in_data     ( data_16b[p]    ),
                .in_last     ( in_last[p]     ),
                .adapt_ready ( adapt_ready[p] ),
                .in_ready    ( in_ready[p]    ),
                .adapt_valid ( adapt_valid[p] ),
                .adapt_beat  ( adapt_beat[p]  ),
                .adapt_last  ( adapt_last[p]  )
            );
        end else begin : g_32b
            ing_port_adapt #(
                .IN_BYTES ( 4 )
            ) u_adapt (
                .ing_bus     ( ing_bus             ),
                .arst_n      ( arst_n              ),
                .in_valid    ( in_valid[p]         ),
                .in_data     ( data_32b[p-NUM_16B] ),
                .in_last     ( in_last[p]          ),
                .adapt_ready ( adapt_ready[p]      ),
                .in_ready    ( in_ready[p]         ),
                .adapt_valid ( adapt_valid[p]      ),
                .adapt_beat  ( adapt_beat[p]       ),
                .adapt_last  ( adapt_last[p]       )
            );
        end

        ing_port_buf u_buf (
            .ing_bus     ( ing_bus        ),
            .arst_n      ( arst_n         ),
            .enable      ( port_enable[p] ),
            .cnt_clear   ( cnt_clear[p]   ),
            .adapt_valid ( adapt_valid[p] ),
            .adapt_beat  ( adapt_beat[p]  ),
            .adapt_last  ( adapt_last[p]  ),
            .desc_pop    ( desc_pop[p]    ),
            .beat_pop    ( beat_pop[p]    ),
            .adapt_ready ( adapt_ready[p] ),
            .desc_avail  ( desc_avail[p]  ),
            .desc_head   ( desc_head[p]   ),
            .beat_head   ( beat_head[p]   ),
            .pkt_cnt     ( pkt_cnt[p]     ),
            .drop_cnt    ( drop_cnt[p]    )
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // Merge onto the ingress bus

    ing_sched u_sched (
        .ing_bus    ( ing_bus    ),
        .arst_n     ( arst_n     ),
        .desc_avail ( desc_avail ),
        .desc_head  ( desc_head  ),
        .beat_head  ( beat_head  ),
        .bus_ready  ( bus_ready  ),
        .desc_pop   ( desc_pop   ),
        .beat_pop   ( beat_pop   ),
        .bus_valid  ( bus_valid  ),
        .bus_data   ( bus_data   ),
        .bus_keep   ( bus_keep   ),
        .bus_last   ( bus_last   ),
        .bus_user   ( bus_user   )
    );

endmodule

`default_nettype wire

//--- bench/tb_ing_top.sv
// Self-checking testbench for the ingress stage of the packet router
// Drives all four ports and checks the ingress bus against a per-port model
`timescale 1ns/1ps
`default_nettype none
`include "ing_defines.svh"

module tb_ing_top;

    localparam int NB         = `ING_BUS_BYTES;
    localparam int DW         = NB * 8;
    localparam int EW         = DW + NB + 1;
    localparam int BEAT_LIMIT = `ING_BEAT_DEPTH - `ING_MAX_PKT_BEATS;
    localparam int WAIT_LIMIT = 4000;

    logic                        ing_bus;
    logic                        arst_n;
    logic [`ING_NUM_PORTS-1:0]   in_valid;
    logic [15:0]                 in_data_0;
    logic [15:0]                 in_data_1;
    logic [31:0]                 in_data_2;
    logic [31:0]                 in_data_3;
    logic [`ING_NUM_PORTS-1:0]   in_last;
    logic [`ING_NUM_PORTS-1:0]   port_enable;
    logic [`ING_NUM_PORTS-1:0]   cnt_clear;
    logic                        bus_ready;
    logic [`ING_NUM_PORTS-1:0]   in_ready;
    logic                        bus_valid;
    logic [DW-1:0]               bus_data;
    logic [NB-1:0]               bus_keep;
    logic                        bus_last;
    logic [`ING_PORT_IDX_W-1:0]  bus_user;
    logic [`ING_CNT_W-1:0]       pkt_cnt  [`ING_NUM_PORTS-1:0];
    logic [`ING_CNT_W-1:0]       drop_cnt [`ING_NUM_PORTS-1:0];

    // Reference model state, one entry is {last, keep, data}
    logic [15:0]   lfsr;
    logic [EW-1:0] exp_q [`ING_NUM_PORTS][$];
    int            exp_pkt   [`ING_NUM_PORTS];
    int            exp_drop  [`ING_NUM_PORTS];
    int            pend_pkts [`ING_NUM_PORTS];
    bit            hold_phase;
    int            hold_owner;
    bit            toggling;
    bit            mid_pkt;
    int            pkt_port;

    ing_top u_ing_top (.*);

    initial begin
        ing_bus = 1'b0;
        forever #4 ing_bus = ~ing_bus;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers

    task automatic value_error(input string name, input logic [63:0] expv,
                               input logic [63:0] actv);
        $display("** Error at %0t: %s expected %0h, actual %0h", $time, name, expv, actv);
        $display("TESTS FAILED");
        $fatal(1, "stopping on first error");
    endtask

    task automatic abort_run(input string why);
        $display("Error at %0t: %s", $time, why);
        $display("TESTS FAILED");
        $fatal(1, "stopping on first error");
    endtask

    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic int total_pending();
        int n;
        n = 0;
        for (int p = 0; p < `ING_NUM_PORTS; p++) begin
            n += exp_q[p].size();
        end
        return n;
    endfunction

    task automatic drive_data(input int p, input logic [31:0] d);
        case (p)
            0: in_data_0 <= d[15:0];
            1: in_data_1 <= d[15:0];
            2: in_data_2 <= d;
            default: in_data_3 <= d;
        endcase
    endtask

    // Predicts the packet's fate, queues its wide beats, then drives it
    task automatic send_packet(input int p, input int nbeats);
        logic [31:0] nd [32];
        logic [DW-1:0] wdata;
        logic [NB-1:0] wkeep;
        int            bpb;
        int            lanes;
        int            lane;
        int            held;
        int            t;
        bit            store;
        bit            last_beat;
        bpb   = (p < 2) ? 2 : 4;
        lanes = NB / bpb;
        t     = 0;
        // Outside hold phases, wait for room so that nothing is dropped
        while (!hold_phase && (exp_q[p].size() > BEAT_LIMIT ||
                               pend_pkts[p] >= `ING_DESC_DEPTH)) begin
            @(negedge ing_bus);
            t++;
            if (t > WAIT_LIMIT) abort_run("timeout waiting for buffer room");
        end
        // The scheduler has already taken the descriptor of the held packet
        held  = (hold_phase && hold_owner == p) ? 1 : 0;
        store = port_enable[p] && (exp_q[p].size() <= BEAT_LIMIT) &&
                (pend_pkts[p] - held < `ING_DESC_DEPTH);
        if (store) begin
            exp_pkt[p]++;
            pend_pkts[p]++;
            if (hold_phase && hold_owner < 0) hold_owner = p;
        end else if (port_enable[p]) begin
            exp_drop[p]++;
        end

        lane  = 0;
        wdata = '0;
        wkeep = '0;
        for (int i = 0; i < nbeats; i++) begin
            nd[i] = rand_bits(bpb * 8);
            for (int b = 0; b < bpb; b++) begin
                wdata[(lane * bpb + b) * 8 +: 8] = nd[i][b * 8 +: 8];
                wkeep[lane * bpb + b]            = 1'b1;
            end
            lane++;
            last_beat = (i == nbeats - 1);
            if (lane == lanes || last_beat) begin
                if (store) exp_q[p].push_back({last_beat, wkeep, wdata});
                lane  = 0;
                wdata = '0;
                wkeep = '0;
            end
        end

        @(posedge ing_bus);
        for (int i = 0; i < nbeats; i++) begin
            in_valid[p] <= 1'b1;
            in_last[p]  <= (i == nbeats - 1);
            drive_data(p, nd[i]);
            t = 0;
            do begin
                @(negedge ing_bus);
                t++;
                assert (port_enable[p] || in_ready[p])
                    else abort_run("disabled port stalled its input");
                if (t > WAIT_LIMIT) abort_run("timeout waiting for in_ready");
            end while (!in_ready[p]);
            @(posedge ing_bus);
        end
        in_valid[p] <= 1'b0;
        in_last[p]  <= 1'b0;
    endtask

    task automatic send_burst(input int p, input int npkts);
        int len;
        for (int k = 0; k < npkts; k++) begin
            if (p < 2) len = int'(rand_bits(5)) + 1;
            else len = int'(rand_bits(4)) + 1;
            send_packet(p, len);
        end
    endtask

    task automatic toggle_ready();
        while (toggling) begin
            @(posedge ing_bus);
            bus_ready <= (rand_bits(1) != 0);
        end
        @(posedge ing_bus);
        bus_ready <= 1'b1;
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (total_pending() != 0) begin
            @(negedge ing_bus);
            t++;
            if (t > WAIT_LIMIT) abort_run("timeout waiting for the ingress bus to drain");
        end
        // Late beats from a wrongly stored packet would show up here
        repeat (10) @(negedge ing_bus);
        assert (!bus_valid) else value_error("bus_valid", 64'(0), 64'(bus_valid));
    endtask

    task automatic check_counters();
        @(negedge ing_bus);
        for (int p = 0; p < `ING_NUM_PORTS; p++) begin
            assert (pkt_cnt[p] == `ING_CNT_W'(exp_pkt[p]))
                else value_error($sformatf("pkt_cnt[%0d]", p), 64'(exp_pkt[p]), 64'(pkt_cnt[p]));
            assert (drop_cnt[p] == `ING_CNT_W'(exp_drop[p]))
                else value_error($sformatf("drop_cnt[%0d]", p), 64'(exp_drop[p]),
                                 64'(drop_cnt[p]));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Ingress bus monitor

    // A transfer seen here completes on the next rising edge
    always @(negedge ing_bus) begin : bus_monitor
        logic [EW-1:0] exp_beat;
        logic [DW-1:0] mask;
        int            u;
        if (arst_n && bus_valid && bus_ready) begin
            u = int'(bus_user);
            assert (exp_q[u].size() > 0)
                else abort_run($sformatf("beat from port %0d with no packet expected", u));
            assert (!mid_pkt || u == pkt_port)
                else value_error("bus_user", 64'(pkt_port), 64'(u));
            exp_beat = exp_q[u].pop_front();
            for (int b = 0; b < NB; b++) begin
                mask[b * 8 +: 8] = {8{exp_beat[DW + b]}};
            end
            assert ((bus_data & mask) == (exp_beat[DW-1:0] & mask))
                else value_error("bus_data", exp_beat[DW-1:0] & mask, bus_data & mask);
            assert (bus_keep == exp_beat[DW +: NB])
                else value_error("bus_keep", 64'(exp_beat[DW +: NB]), 64'(bus_keep));
            assert (bus_last == exp_beat[EW-1])
                else value_error("bus_last", 64'(exp_beat[EW-1]), 64'(bus_last));
            mid_pkt  = !bus_last;
            pkt_port = u;
            if (bus_last) pend_pkts[u]--;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        lfsr        = 16'd1324;
        arst_n      = 1'b0;
        in_valid    = '0;
        in_data_0   = '0;
        in_data_1   = '0;
        in_data_2   = '0;
        in_data_3   = '0;
        in_last     = '0;
        port_enable = '1;
        cnt_clear   = '0;
        bus_ready   = 1'b0;
        hold_phase  = 1'b0;
        hold_owner  = -1;
        toggling    = 1'b0;
        mid_pkt     = 1'b0;
        pkt_port    = 0;
        for (int p = 0; p < `ING_NUM_PORTS; p++) begin
            exp_pkt[p]   = 0;
            exp_drop[p]  = 0;
            pend_pkts[p] = 0;
        end
        repeat (8) @(posedge ing_bus);
        arst_n <= 1'b1;

        // Idle state after reset
        @(negedge ing_bus);
        assert (!bus_valid) else value_error("bus_valid", 64'(0), 64'(bus_valid));
        check_counters();

        // Single-port packets, partial last beats included
        @(posedge ing_bus);
        bus_ready <= 1'b1;
        send_packet(0, 1);
        send_packet(0, 3);
        send_packet(0, 4);
        send_packet(0, 5);
        send_packet(0, 8);
        send_packet(2, 1);
        send_packet(2, 2);
        send_packet(2, 3);
        wait_drain();
        check_counters();

        // All ports at once with random back-pressure
        toggling = 1'b1;
        fork
            toggle_ready();
            begin
                fork
                    send_burst(0, 6);
                    send_burst(1, 6);
                    send_burst(2, 6);
                    send_burst(3, 6);
                join
                toggling = 1'b0;
            end
        join
        wait_drain();
        check_counters();

        // Bus stalled: beat FIFO overflow on port 0, descriptor FIFO on port 2
        @(posedge ing_bus);
        bus_ready  <= 1'b0;
        hold_phase = 1'b1;
        hold_owner = -1;
        repeat (3) send_packet(0, 32);
        repeat (5) send_packet(2, 1);
        repeat (4) @(posedge ing_bus);
        check_counters();
        hold_phase = 1'b0;
        @(posedge ing_bus);
        bus_ready <= 1'b1;
        wait_drain();
        check_counters();

        // Disabled port swallows its packet
        @(posedge ing_bus);
        port_enable[1] <= 1'b0;
        @(posedge ing_bus);
        send_packet(1, 6);
        wait_drain();
        check_counters();
        @(posedge ing_bus);
        port_enable[1] <= 1'b1;

        // Counter clear on port 2 only, which has both counters nonzero
        @(posedge ing_bus);
        cnt_clear[2] <= 1'b1;
        @(posedge ing_bus);
        cnt_clear[2] <= 1'b0;
        exp_pkt[2]  = 0;
        exp_drop[2] = 0;
        check_counters();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+common
common/ing_pkg.sv
ing_port_buf/ing_pkt_fifo.sv
ing_port_buf/ing_port_buf.sv
hw/ing_port_adapt.sv
hw/ing_sched.sv
hw/ing_top.sv
bench/tb_ing_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the ingress stage testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_ing_top -f tb.f; then
    echo "Verilator build failed"
    exit 1
fi

sim_out="$(./obj_dir/Vtb_ing_top)"
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "TESTS PASSED"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1
